/* capture_pkg.sv */
package capture_pkg;

  // sample and word widths of the capture channel.
  localparam int sample_w = 16;
  localparam int word_w   = 32;

  // the strobe buffer holds eight entries. Its pointers carry one extra bit.
  localparam int fifo_depth = 8;
  localparam int fifo_aw    = 3;

  typedef logic [sample_w-1:0] sample_t;
  typedef logic [word_w-1:0]   word_t;

  // number of samples per frame, 1 to 255.
  typedef logic [7:0] frame_len_t;

  // one sample with its end-of-frame marker.
  typedef struct packed {
    logic    last;
    sample_t data;
  } sample_beat_t;

  // one packed output word with its end-of-frame marker.
  typedef struct packed {
    logic  last;
    word_t data;
  } word_beat_t;

endpackage

/* frame_marker.sv */
`timescale 1ns/1ps

module frame_marker (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      sample_valid,
  input  capture_pkg::sample_t      sample,
  input  capture_pkg::frame_len_t   frame_len,
  output logic                      mark_valid,
  output capture_pkg::sample_beat_t mark_beat
);

  capture_pkg::frame_len_t count;
  capture_pkg::frame_len_t len_q;
  capture_pkg::frame_len_t eff_len;
  logic                    frame_start;
  logic                    is_last;

  // a count of zero means the next strobe opens a frame.
  assign frame_start = (count == '0);

  // the first sample of a frame compares against the length being latched.
  assign eff_len = frame_start ? frame_len : len_q;
  assign is_last = (count == (eff_len - capture_pkg::frame_len_t'(1)));

  always_ff @(posedge clk) begin
    if (rst) begin
      count      <= '0;
      len_q      <= '0;
      mark_valid <= 1'b0;
    end else begin
      mark_valid <= sample_valid;
      if (sample_valid) begin
        if (frame_start) begin
          len_q <= frame_len;
        end
        if (is_last) begin
          count <= '0;
        end else begin
          count <= count + capture_pkg::frame_len_t'(1);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample_valid) begin
      mark_beat.last <= is_last;
      mark_beat.data <= sample;
    end
  end

  // a zero length lies outside the frame range of 1 to 255.
  frame_len_nonzero_a : assert property (
    @(posedge clk) disable iff (rst)
    (sample_valid && frame_start) |-> (frame_len != '0)
  );

endmodule

/* strobe_rx_fifo.sv */
`timescale 1ns/1ps

module strobe_rx_fifo (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      mark_valid,
  input  capture_pkg::sample_beat_t mark_beat,
  input  logic                      buf_ready,
  output logic                      buf_valid,
  output capture_pkg::sample_beat_t buf_beat,
  output logic                      overflow
);

  typedef logic [capture_pkg::fifo_aw:0] ptr_t;

  capture_pkg::sample_beat_t mem [capture_pkg::fifo_depth];

  ptr_t wptr;
  ptr_t rptr;
  logic empty;
  logic full;
  logic load;
  logic pop;
  logic drop;

  assign empty = (wptr == rptr);

  // full when the index bits match and the wrap bits differ.
  assign full = (wptr[capture_pkg::fifo_aw] != rptr[capture_pkg::fifo_aw]) &&
                (wptr[capture_pkg::fifo_aw-1:0] == rptr[capture_pkg::fifo_aw-1:0]);

  // the output register reloads when it is empty or being taken.
  assign load = buf_ready || !buf_valid;
  assign pop  = load && !empty;

  // a write into a full buffer that is not being read replaces the oldest
  // entry. The read pointer steps past it so the order stays intact.
  assign drop = mark_valid && full && !pop;

  always_ff @(posedge clk) begin
    if (rst) begin
      wptr      <= '0;
      rptr      <= '0;
      buf_valid <= 1'b0;
      overflow  <= 1'b0;
    end else begin
      if (mark_valid) begin
        wptr <= wptr + ptr_t'(1);
      end
      if (pop || drop) begin
        rptr <= rptr + ptr_t'(1);
      end
      if (load) begin
        buf_valid <= !empty;
      end
      // sticky until reset.
      if (drop) begin
        overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mark_valid) begin
      mem[wptr[capture_pkg::fifo_aw-1:0]] <= mark_beat;
    end
    if (pop) begin
      buf_beat <= mem[rptr[capture_pkg::fifo_aw-1:0]];
    end
  end

  // a stalled beat must not change under the packer.
  buf_hold_a : assert property (
    @(posedge clk) disable iff (rst)
    (buf_valid && !buf_ready) |=> (buf_valid && $stable(buf_beat))
  );

  buf_reset_a : assert property (
    @(posedge clk)
    rst |=> !buf_valid
  );

endmodule

/* sample_packer.sv */
`timescale 1ns/1ps

module sample_packer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      buf_valid,
  input  capture_pkg::sample_beat_t buf_beat,
  input  logic                      out_ready,
  output logic                      buf_ready,
  output logic                      out_valid,
  output capture_pkg::word_beat_t   out_beat
);

  typedef enum logic {
    hold_empty,
    hold_full
  } hold_state_t;

  hold_state_t          state;
  capture_pkg::sample_t hold_data;
  capture_pkg::word_t   word_next;
  logic                 out_free;
  logic                 take;
  logic                 to_hold;
  logic                 to_word;

  // the output register can accept a new word this cycle.
  assign out_free = !out_valid || out_ready;

  // a sample parked in the low half never needs the output register. Any
  // sample that closes a word does.
  assign buf_ready = out_free || ((state == hold_empty) && !buf_beat.last);

  assign take    = buf_valid && buf_ready;
  assign to_hold = take && (state == hold_empty) && !buf_beat.last;
  assign to_word = take && !to_hold;

  // earlier sample in the low half. A lone last sample gets a zero high half.
  always_comb begin
    if (state == hold_full) begin
      word_next = {buf_beat.data, hold_data};
    end else begin
      word_next = {capture_pkg::sample_t'(0), buf_beat.data};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= hold_empty;
      out_valid <= 1'b0;
    end else begin
      if (to_word) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
      if (to_hold) begin
        state <= hold_full;
      end else if (to_word) begin
        state <= hold_empty;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (to_hold) begin
      hold_data <= buf_beat.data;
    end
    if (to_word) begin
      out_beat.last <= buf_beat.last;
      out_beat.data <= word_next;
    end
  end

  out_hold_a : assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
  );

endmodule

/* capture_top.sv */
`timescale 1ns/1ps

module capture_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    sample_valid,
  input  capture_pkg::sample_t    sample,
  input  capture_pkg::frame_len_t frame_len,
  input  logic                    out_ready,
  output logic                    out_valid,
  output capture_pkg::word_beat_t out_beat,
  output logic                    overflow
);

  logic                      mark_valid;
  capture_pkg::sample_beat_t mark_beat;
  logic                      buf_valid;
  logic                      buf_ready;
  capture_pkg::sample_beat_t buf_beat;

  frame_marker u_frame_marker (
    .clk          (clk),
    .rst          (rst),
    .sample_valid (sample_valid),
    .sample       (sample),
    .frame_len    (frame_len),
    .mark_valid   (mark_valid),
    .mark_beat    (mark_beat)
  );

  // no back-pressure reaches the source. Overruns show up on overflow.
  strobe_rx_fifo u_strobe_rx_fifo (
    .clk        (clk),
    .rst        (rst),
    .mark_valid (mark_valid),
    .mark_beat  (mark_beat),
    .buf_ready  (buf_ready),
    .buf_valid  (buf_valid),
    .buf_beat   (buf_beat),
    .overflow   (overflow)
  );

  sample_packer u_sample_packer (
    .clk       (clk),
    .rst       (rst),
    .buf_valid (buf_valid),
    .buf_beat  (buf_beat),
    .out_ready (out_ready),
    .buf_ready (buf_ready),
    .out_valid (out_valid),
    .out_beat  (out_beat)
  );

endmodule

/* capture_top_tb.sv */
`timescale 1ns/1ps

module capture_top_tb;

  localparam int reset_cycles = 16;
  localparam int word_timeout = 200;
  localparam int flag_timeout = 40;

  logic                    clk;
  logic                    rst;
  logic                    sample_valid;
  capture_pkg::sample_t    sample;
  capture_pkg::frame_len_t frame_len;
  logic                    out_ready;
  logic                    out_valid;
  capture_pkg::word_beat_t out_beat;
  logic                    overflow;

  int          mismatch_count;
  int          failure_count;
  logic [31:0] data_seed;
  logic [31:0] ready_seed;
  logic        ready_done;

  // reference model state, rebuilt from the pairing rule.
  capture_pkg::word_beat_t exp_q[$];
  capture_pkg::frame_len_t cur_len;
  capture_pkg::frame_len_t model_len;
  capture_pkg::frame_len_t model_count;
  capture_pkg::sample_t    model_half;
  logic                    model_half_full;

  capture_top UUT (
    .clk          (clk),
    .rst          (rst),
    .sample_valid (sample_valid),
    .sample       (sample),
    .frame_len    (frame_len),
    .out_ready    (out_ready),
    .out_valid    (out_valid),
    .out_beat     (out_beat),
    .overflow     (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_word(input string name, input capture_pkg::word_t got,
                            input capture_pkg::word_t want);
    if (got !== want) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, want);
      mismatch_count++;
    end
  endtask

  task automatic check_last(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, want);
      mismatch_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, want);
      mismatch_count++;
    end
  endtask

  task automatic note_failure(input string what);
    $display("%s", what);
    failure_count++;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst          <= 1'b1;
    sample_valid <= 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    exp_q.delete();
    model_count     = '0;
    model_half_full = 1'b0;
  endtask

  task automatic set_frame_len(input capture_pkg::frame_len_t len);
    @(posedge clk);
    frame_len <= len;
    cur_len = len;
  endtask

  // earlier sample in the low half. A last sample closes its word at once.
  task automatic model_sample(input capture_pkg::sample_t s);
    capture_pkg::word_beat_t w;
    logic                    last;
    if (model_count == 8'd0) begin
      model_len = cur_len;
    end
    last = (model_count == model_len - 8'd1);
    if (model_half_full) begin
      w.data = {s, model_half};
      w.last = last;
      exp_q.push_back(w);
      model_half_full = 1'b0;
    end else if (last) begin
      w.data = {capture_pkg::sample_t'(0), s};
      w.last = 1'b1;
      exp_q.push_back(w);
    end else begin
      model_half      = s;
      model_half_full = 1'b1;
    end
    model_count = last ? 8'd0 : model_count + 8'd1;
  endtask

  task automatic send_sample(input capture_pkg::sample_t s, input int gap);
    @(posedge clk);
    sample_valid <= 1'b1;
    sample       <= s;
    model_sample(s);
    @(posedge clk);
    sample_valid <= 1'b0;
    repeat (gap - 2) @(posedge clk);
  endtask

  task automatic send_frames(input int frames, input int gap);
    for (int i = 0; i < frames * int'(cur_len); i++) begin
      data_seed = lcg(data_seed);
      send_sample(data_seed[31:16], gap);
    end
  endtask

  task automatic collect_words(input int n);
    capture_pkg::word_beat_t want;
    int                      got_n;
    int                      idle;
    got_n = 0;
    idle  = 0;
    while (got_n < n && idle < word_timeout) begin
      @(posedge clk);
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          note_failure("a word arrived that the model did not expect");
        end else begin
          want = exp_q.pop_front();
          check_word("out_beat.data", out_beat.data, want.data);
          check_last("out_beat.last", out_beat.last, want.last);
        end
        got_n++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    if (got_n < n) begin
      note_failure("timed out waiting for output words");
    end
  endtask

  task automatic check_drained();
    if (exp_q.size() != 0) begin
      note_failure("expected words are left over after the run");
      exp_q.delete();
    end
    repeat (10) begin
      @(posedge clk);
      if (out_valid && out_ready) begin
        note_failure("an extra word arrived after the run");
      end
    end
  endtask

  task automatic wait_overflow();
    int n;
    n = 0;
    while (!overflow && n < flag_timeout) begin
      @(posedge clk);
      n++;
    end
    if (!overflow) begin
      note_failure("timed out waiting for overflow to set");
    end
  endtask

  task automatic drain_output();
    int n;
    int idle;
    n    = 0;
    idle = 0;
    while (idle < 10 && n < word_timeout) begin
      @(posedge clk);
      idle = out_valid ? 0 : idle + 1;
      n++;
    end
    if (idle < 10) begin
      note_failure("timed out waiting for the output to drain");
    end
    exp_q.delete();
  endtask

  task automatic test_reset_state();
    repeat (4) @(posedge clk);
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("overflow", overflow, 1'b0);
  endtask

  task automatic test_even_frames();
    @(posedge clk);
    out_ready <= 1'b1;
    set_frame_len(8'd6);
    fork
      send_frames(2, 2);
      collect_words(6);
    join
    check_drained();
    check_flag("overflow", overflow, 1'b0);
  endtask

  // the odd frame ends on a lone sample, and the next frame pairs afresh.
  task automatic test_odd_frames();
    set_frame_len(8'd5);
    fork
      send_frames(2, 2);
      collect_words(6);
    join
    check_drained();
    check_flag("overflow", overflow, 1'b0);
  endtask

  task automatic test_random_ready();
    int n;
    set_frame_len(8'd7);
    ready_done = 1'b0;
    n = 0;
    fork
      send_frames(3, 4);
      begin
        collect_words(12);
        ready_done = 1'b1;
      end
      begin
        while (!ready_done && n < 5000) begin
          @(posedge clk);
          ready_seed = lcg(ready_seed);
          out_ready <= ready_seed[28];
          n++;
        end
      end
    join
    @(posedge clk);
    out_ready <= 1'b1;
    check_drained();
    check_flag("overflow", overflow, 1'b0);
  endtask

  task automatic test_backpressure();
    @(posedge clk);
    out_ready <= 1'b0;
    set_frame_len(capture_pkg::frame_len_t'(capture_pkg::fifo_depth));
    send_frames(1, 2);
    @(posedge clk);
    out_ready <= 1'b1;
    collect_words(capture_pkg::fifo_depth / 2);
    check_drained();
    check_flag("overflow", overflow, 1'b0);

    // thirty strobes overrun the buffer while the sink is stalled.
    apply_reset();
    @(posedge clk);
    out_ready <= 1'b0;
    set_frame_len(8'd10);
    send_frames(3, 2);
    wait_overflow();
    check_flag("overflow", overflow, 1'b1);
    @(posedge clk);
    out_ready <= 1'b1;
    drain_output();
    check_flag("overflow", overflow, 1'b1);
  endtask

  initial begin
    rst             = 1'b1;
    sample_valid    = 1'b0;
    sample          = '0;
    frame_len       = 8'd1;
    out_ready       = 1'b0;
    mismatch_count  = 0;
    failure_count   = 0;
    data_seed       = 32'd71242;
    ready_seed      = 32'd71242;
    ready_done      = 1'b0;
    cur_len         = 8'd1;
    model_len       = 8'd1;
    model_count     = '0;
    model_half      = '0;
    model_half_full = 1'b0;

    apply_reset();
    test_reset_state();
    test_even_frames();
    test_odd_frames();
    test_random_ready();
    test_backpressure();

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* capture_top.f */
capture_pkg.sv
frame_marker.sv
strobe_rx_fifo.sv
sample_packer.sv
capture_top.sv
capture_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the capture channel testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module capture_top_tb -o capture_sim \
  -f capture_top.f > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status, see build.log"
  exit 1
fi

./obj_dir/capture_sim > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status, see sim.log"
  exit 1
fi

if grep -qx "Test passed" sim.log; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see sim.log"
exit 1
